// File: sim.f
+incdir+verilog
verilog/ddr_rx_pkg.sv
verilog/wb_pkg.sv
verilog/ddr_in_cell.sv
verilog/ddr_rx_gearbox.sv
verilog/ddr_rx_fifo.sv
verilog/ddr_rx_wb_regs.sv
verilog/ddr_rx_top.sv
verif/ddr_rx_properties.sv
verif/ddr_rx_tb.sv

// File: Makefile
# verilator build and run of the ddr receiver testbench
TOP = ddr_rx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir

# the log decides pass or fail
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

// File: verif/ddr_rx_tb.sv
// testbench for the ddr receiver top level, single clock, verilator --timing
// ddr_in changes a quarter period after each clock edge, wishbone on falling edges
// stream data is only checked in pipe mode, other modes use static lane values
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rx_defines.svh"

module ddr_rx_tb
   import ddr_rx_pkg::*;
   import wb_pkg::*;
();

   // overflow fill plus polling is the longest test, about 80 cycles;
   // all six tests stay under 400 cycles, limit is ten times that
   localparam int TEST_CYCLES = 400;
   localparam int MAX_CYCLES  = 10 * TEST_CYCLES;

   logic                  clk;
   logic                  rst;
   logic [`DDR_LANES-1:0] ddr_in;
   wb_req_t               wb_req;
   wb_rsp_t               wb_rsp;

   int          seed = 12;
   logic [7:0]  stream_base;     // first stream value, from $random
   int          drv_idx;         // stream index of the pair being driven
   logic        stream_on;       // 0 drives static_in on both edges
   logic [3:0]  static_in;
   logic [31:0] got_q[$];        // pipe words waiting for the compare process
   int          n_checks;
   int          n_errors;
   int          test_err_base;   // error count at start of current test
   int          cycles;

   ddr_rx_top u_ddr_rx_top (
      .clk    (clk),
      .rst    (rst),
      .ddr_in (ddr_in),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   // ######################################
   // reference model
   // ######################################
   // stream is a byte counter starting at stream_base
   function automatic logic [7:0] stream_value(input int idx);
      return stream_base + 8'(idx);
   endfunction

   // word from four stream values, first value in byte 0
   function automatic logic [31:0] expected_word(input logic [7:0] offset);
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < `DDR_BEATS; i++)
      begin
         w[8*i +: 8] = stream_value(int'(offset) + i);
      end
      return w;
   endfunction

   // ######################################
   // ddr stream driver
   // ######################################
   // low nibble (rise bits) settles before the posedge,
   // high nibble (fall bits) before the following negedge
   initial
   begin : ddr_driver
      logic [7:0] v;
      ddr_in  = '0;
      drv_idx = 0;
      forever
      begin
         @(negedge clk);
         #5;
         v      = stream_value(drv_idx);
         ddr_in = stream_on ? v[3:0] : static_in; // rise nibble
         @(posedge clk);
         #5;
         ddr_in = stream_on ? v[7:4] : static_in; // fall nibble
         drv_idx++;
      end
   end

   // ######################################
   // checks and bus tasks
   // ######################################
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      n_checks++;
      if (actual !== expected)
      begin
         n_errors++;
         $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
      end
   endtask

   task automatic end_test(input string name);
      if (n_errors == test_err_base)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         $display("test %s: %0d errors", name, n_errors - test_err_base);
      end
      test_err_base = n_errors;
   endtask

   // ack is registered, stable by the falling edge
   task automatic wait_ack();
      do
      begin
         @(negedge clk);
      end
      while (!wb_rsp.ack);
   endtask

   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
      @(negedge clk);
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
      wait_ack();
      wb_req = '0; // drop the cycle once ack is seen
   endtask

   task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
      @(negedge clk);
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 32'd0};
      wait_ack();
      data   = wb_rsp.dat;
      wb_req = '0;
   endtask

   // pipe word compare, first word fixes the stream offset
   initial
   begin : word_compare
      logic [31:0] w;
      logic [7:0]  off;
      logic        have_off;
      have_off = 1'b0;
      off      = '0;
      forever
      begin
         @(posedge clk);
         while (got_q.size() != 0)
         begin
            w = got_q.pop_front();
            if (!have_off)
            begin
               off      = w[7:0] - stream_base;
               have_off = 1'b1;
               $display("pipe capture starts at stream offset %0d", off);
            end
            check_value("pipe word", expected_word(off), w);
            off = off + 8'(`DDR_BEATS);
         end
      end
   end

   // ######################################
   // watchdog
   // ######################################
   initial
   begin : watchdog
      cycles = 0;
      while (cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   // ######################################
   // test sequence
   // ######################################
   initial
   begin : main
      logic [31:0] rdata;
      int          words;
      rst           = 1'b1;
      wb_req        = '0;
      stream_on     = 1'b0;
      static_in     = 4'h0;
      n_checks      = 0;
      n_errors      = 0;
      test_err_base = 0;
      stream_base   = 8'($random(seed));
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // 1: reset state and ctrl readback
      read_reg(`DDR_REG_STATUS, rdata);
      check_value("reset status", 32'h0000_0200, rdata); // empty, level 0
      write_reg(`DDR_REG_CTRL, 32'h3);                    // pipe, capture off
      read_reg(`DDR_REG_CTRL, rdata);
      check_value("ctrl readback", 32'h3, rdata);
      end_test("reset and ctrl");

      // 2: bypass, rise is the live pin, fall is 0
      static_in = 4'ha;
      write_reg(`DDR_REG_CTRL, 32'h0);
      repeat (2) @(negedge clk);
      read_reg(`DDR_REG_SAMPLE, rdata);
      check_value("bypass sample", 32'h0000_000a, rdata);
      end_test("bypass");

      // 3: sample and align, static pins show on both edges
      static_in = 4'h5;
      write_reg(`DDR_REG_CTRL, 32'h1);
      repeat (3) @(negedge clk);
      read_reg(`DDR_REG_SAMPLE, rdata);
      check_value("sample mode", 32'h0000_0055, rdata);
      static_in = 4'hc;
      write_reg(`DDR_REG_CTRL, 32'h2);
      repeat (3) @(negedge clk);
      read_reg(`DDR_REG_SAMPLE, rdata);
      check_value("align mode", 32'h0000_00cc, rdata);
      end_test("sample and align");

      // 4: pipe capture of the running stream
      stream_on = 1'b1;
      repeat (4) @(negedge clk);           // cells fill with stream data
      write_reg(`DDR_REG_CTRL, 32'h7);     // pipe, capture on
      rdata = '0;
      while (rdata[7:0] < 8'd4)
      begin
         read_reg(`DDR_REG_STATUS, rdata);
      end
      write_reg(`DDR_REG_CTRL, 32'h3);     // stop before the FIFO fills
      read_reg(`DDR_REG_STATUS, rdata);
      check_value("pipe overflow bit", 32'h0, {31'd0, rdata[8]});
      words = int'(rdata[7:0]);
      for (int i = 0; i < words; i++)
      begin
         read_reg(`DDR_REG_DATA, rdata);
         got_q.push_back(rdata);
      end
      while (got_q.size() != 0) @(posedge clk);
      read_reg(`DDR_REG_STATUS, rdata);
      check_value("pipe drained", 32'h0000_0200, rdata);
      end_test("pipe capture");

      // 5: overflow with capture left on and no reads
      write_reg(`DDR_REG_CTRL, 32'h7);
      rdata = '0;
      while (!rdata[8])
      begin
         read_reg(`DDR_REG_STATUS, rdata);
      end
      repeat (8) @(negedge clk);           // two more words dropped
      read_reg(`DDR_REG_STATUS, rdata);
      check_value("overflow status", 32'h100 | 32'(`DDR_FIFO_DEPTH), rdata);
      write_reg(`DDR_REG_CTRL, 32'h3);
      write_reg(`DDR_REG_STATUS, 32'h100); // clear sticky flag
      read_reg(`DDR_REG_STATUS, rdata);
      check_value("overflow cleared", 32'(`DDR_FIFO_DEPTH), rdata);
      for (int i = 0; i < `DDR_FIFO_DEPTH; i++)
      begin
         read_reg(`DDR_REG_DATA, rdata);
      end
      end_test("overflow");

      // 6: read of an empty FIFO
      read_reg(`DDR_REG_DATA, rdata);
      check_value("empty data", 32'h0, rdata);
      read_reg(`DDR_REG_STATUS, rdata);
      check_value("empty status", 32'h0000_0200, rdata);
      end_test("empty read");

      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/ddr_rx_properties.sv
// bound checks for the wishbone handshake and the FIFO bounds
// one module, bound twice, parameters pick the rule set per target
// all rules are off while rst is high
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rx_defines.svh"

module ddr_rx_properties #(
   parameter bit BUS_CHECKS  = 1'b1,
   parameter bit FIFO_CHECKS = 1'b1
) (
   input logic                    clk,
   input logic                    rst,
   input logic                    cyc,
   input logic                    stb,
   input logic                    ack,
   input logic [`DDR_LEVEL_W-1:0] level,
   input logic                    rd_en,
   input logic                    empty
);

   // ######################################
   // wishbone handshake
   // ######################################
   if (BUS_CHECKS)
   begin : g_bus
      a_ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
         else $error("wishbone ack high for two cycles in a row");
      // ack only follows a cycle with cyc and stb both high
      a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
         ack |-> $past(cyc && stb))
         else $error("wishbone ack without a request");
   end

   // ######################################
   // FIFO bounds
   // ######################################
   if (FIFO_CHECKS)
   begin : g_fifo
      a_level_max: assert property (@(posedge clk) disable iff (rst)
         level <= `DDR_LEVEL_W'(`DDR_FIFO_DEPTH))
         else $error("FIFO level above depth");
      a_no_empty_pop: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
         else $error("FIFO popped while empty");
   end

endmodule

bind ddr_rx_wb_regs ddr_rx_properties #(
   .BUS_CHECKS  (1'b1),
   .FIFO_CHECKS (1'b0)
) u_bus_props (
   .clk   (clk),
   .rst   (rst),
   .cyc   (wb_req.cyc),
   .stb   (wb_req.stb),
   .ack   (wb_rsp.ack),
   .level (level),
   .rd_en (pop),
   .empty (empty)
);

bind ddr_rx_fifo ddr_rx_properties #(
   .BUS_CHECKS  (1'b0),
   .FIFO_CHECKS (1'b1)
) u_fifo_props (
   .clk   (clk),
   .rst   (rst),
   .cyc   (1'b0),
   .stb   (1'b0),
   .ack   (1'b0),
   .level (level),
   .rd_en (rd_en),
   .empty (empty)
);

`default_nettype wire

// File: verilog/ddr_rx_top.sv
// ddr receiver top, single clock domain
// ddr_in must arrive on the already shifted clk, no training is done
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rx_defines.svh"

module ddr_rx_top
   import ddr_rx_pkg::*;
   import wb_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`DDR_LANES-1:0] ddr_in,
   input  wb_req_t               wb_req,
   output wb_rsp_t               wb_rsp
);

   rx_mode_e                mode;
   logic                    capture_en;
   logic [`DDR_LANES-1:0]   rise;
   logic [`DDR_LANES-1:0]   fall;
   rx_pair_t                pair;
   logic [`DDR_WORD_W-1:0]  word;
   logic                    word_valid;
   logic [`DDR_WORD_W-1:0]  fifo_data;
   logic [`DDR_LEVEL_W-1:0] level;
   logic                    empty;
   logic                    overflow;
   logic                    pop;
   logic                    clr_overflow;

   // one input cell per lane
   for (genvar i = 0; i < `DDR_LANES; i++)
   begin : g_lane
      ddr_in_cell u_cell (
         .clk   (clk),
         .in    (ddr_in[i]),
         .mode  (mode),
         .qrise (rise[i]),
         .qfall (fall[i])
      );
   end

   assign pair = '{fall: fall, rise: rise};

   ddr_rx_gearbox u_gearbox (
      .clk        (clk),
      .rst        (rst),
      .capture_en (capture_en),
      .pair       (pair),
      .word       (word),
      .word_valid (word_valid)
   );

   ddr_rx_fifo u_fifo (
      .clk          (clk),
      .rst          (rst),
      .wr_data      (word),
      .wr_en        (word_valid),
      .rd_en        (pop),
      .rd_data      (fifo_data),
      .level        (level),
      .empty        (empty),
      .overflow     (overflow),
      .clr_overflow (clr_overflow)
   );

   ddr_rx_wb_regs u_regs (
      .clk          (clk),
      .rst          (rst),
      .wb_req       (wb_req),
      .wb_rsp       (wb_rsp),
      .mode         (mode),
      .capture_en   (capture_en),
      .pair         (pair),
      .fifo_data    (fifo_data),
      .level        (level),
      .empty        (empty),
      .overflow     (overflow),
      .pop          (pop),
      .clr_overflow (clr_overflow)
   );

endmodule

`default_nettype wire

// File: verilog/ddr_rx_wb_regs.sv
// wishbone classic slave with a one cycle ack and no wait states or errors
// CTRL    [1:0] mode, [2] capture_en
// STATUS  [7:0] level, [8] overflow (write 1 clears), [9] empty
// DATA    read pops the FIFO and reads 0 when empty
// SAMPLE  [7:0] live rx pair
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rx_defines.svh"

module ddr_rx_wb_regs
   import ddr_rx_pkg::*;
   import wb_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  wb_req_t                 wb_req,
   output wb_rsp_t                 wb_rsp,
   output rx_mode_e                mode,
   output logic                    capture_en,
   input  rx_pair_t                pair,
   input  logic [`DDR_WORD_W-1:0]  fifo_data,
   input  logic [`DDR_LEVEL_W-1:0] level,
   input  logic                    empty,
   input  logic                    overflow,
   output logic                    pop,
   output logic                    clr_overflow
);

   logic             ack_q;
   logic [WB_DW-1:0] dat_q;   // registered read data
   logic             pop_q;   // high in the ack cycle of a DATA read
   logic             clr_q;
   rx_mode_e         mode_q;
   logic             cap_q;
   logic             hit;
   reg_addr_e        addr;

   // new request only when no ack is outstanding
   assign hit  = wb_req.cyc && wb_req.stb && !ack_q;
   assign addr = reg_addr_e'(wb_req.adr[3:2]);

   // ######################################
   // handshake and control
   // ######################################
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack_q  <= 1'b0;
         pop_q  <= 1'b0;
         clr_q  <= 1'b0;
         mode_q <= RX_BYPASS;
         cap_q  <= 1'b0;
      end
      else
      begin
         ack_q <= hit;
         pop_q <= hit && !wb_req.we && (addr == REG_DATA) && !empty;
         clr_q <= hit && wb_req.we && (addr == REG_STATUS) && wb_req.dat[8];
         if (hit && wb_req.we && (addr == REG_CTRL))
         begin
            mode_q <= rx_mode_e'(wb_req.dat[1:0]);
            cap_q  <= wb_req.dat[2];
         end
      end
   end

   // ######################################
   // read mux registered with ack
   // ######################################
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         dat_q <= '0;
      end
      else if (hit && !wb_req.we)
      begin
         case (addr)
            REG_CTRL:   dat_q <= {29'd0, cap_q, mode_q};
            REG_STATUS: dat_q <= {22'd0, empty, overflow, 8'(level)};
            REG_DATA:   dat_q <= empty ? '0 : fifo_data; // head word
            default:    dat_q <= {24'd0, pair};          // sample view
         endcase
      end
   end

   assign wb_rsp       = '{ack: ack_q, dat: dat_q};
   assign mode         = mode_q;
   assign capture_en   = cap_q;
   assign pop          = pop_q;
   assign clr_overflow = clr_q;

endmodule

`default_nettype wire

// File: verilog/ddr_rx_fifo.sv
// receive FIFO, show-ahead read data
// a write while full is dropped and sets the sticky overflow flag
// a read while empty is ignored
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rx_defines.svh"

module ddr_rx_fifo (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`DDR_WORD_W-1:0]  wr_data,
   input  logic                    wr_en,
   input  logic                    rd_en,
   output logic [`DDR_WORD_W-1:0]  rd_data,
   output logic [`DDR_LEVEL_W-1:0] level,
   output logic                    empty,
   output logic                    overflow,
   input  logic                    clr_overflow
);

   localparam int AW = $clog2(`DDR_FIFO_DEPTH);

   logic [`DDR_WORD_W-1:0] mem [`DDR_FIFO_DEPTH];
   logic [AW:0]            wr_ptr_q; // extra bit tells full from empty
   logic [AW:0]            rd_ptr_q;
   logic                   ovf_q;
   logic                   full;

   assign level = wr_ptr_q - rd_ptr_q;
   assign empty = (level == '0);
   assign full  = (level == `DDR_LEVEL_W'(`DDR_FIFO_DEPTH));

   // storage, no reset
   always_ff @(posedge clk)
   begin
      if (wr_en && !full)
      begin
         mem[wr_ptr_q[AW-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         ovf_q    <= 1'b0;
      end
      else
      begin
         if (wr_en && !full)  wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_en && !empty) rd_ptr_q <= rd_ptr_q + 1'b1;
         // new overflow wins over a clear on the same edge
         if (wr_en && full)      ovf_q <= 1'b1;
         else if (clr_overflow)  ovf_q <= 1'b0;
      end
   end

   assign rd_data  = mem[rd_ptr_q[AW-1:0]]; // head word
   assign overflow = ovf_q;

endmodule

`default_nettype wire

// File: verilog/ddr_rx_gearbox.sv
// packs one rx pair per clock into DDR_WORD_W bit words
// first pair lands in byte 0 and word_valid pulses the cycle after the last pair
// no alignment search so a word starts wherever capture_en rose
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rx_defines.svh"

module ddr_rx_gearbox
   import ddr_rx_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   capture_en,
   input  rx_pair_t               pair,
   output logic [`DDR_WORD_W-1:0] word,
   output logic                   word_valid
);

   localparam int PAIR_W = $bits(rx_pair_t);
   localparam int CNT_W  = $clog2(`DDR_BEATS);
   localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`DDR_BEATS - 1);

   logic [`DDR_WORD_W-1:0] shift_q; // newest pair enters at the top
   logic [CNT_W-1:0]       beat_q;  // pairs taken into current word
   logic                   valid_q;

   // ######################################
   // data shift
   // ######################################
   // after DDR_BEATS shifts the oldest pair sits in byte 0
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         shift_q <= '0;
      end
      else if (capture_en)
      begin
         shift_q <= {pair, shift_q[`DDR_WORD_W-1:PAIR_W]};
      end
   end

   // ######################################
   // beat counter
   // ######################################
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         beat_q  <= '0;
         valid_q <= 1'b0;
      end
      else if (!capture_en)
      begin
         beat_q  <= '0;   // drop any partial word
         valid_q <= 1'b0;
      end
      else
      begin
         valid_q <= (beat_q == LAST_BEAT); // word complete after this edge
         if (beat_q == LAST_BEAT)
         begin
            beat_q <= '0;
         end
         else
         begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   // shift_q still holds the full word while valid_q is high
   // and the next pair only replaces it at the end of that cycle
   assign word       = shift_q;
   assign word_valid = valid_q;

endmodule

`default_nettype wire

// File: verilog/ddr_in_cell.sv
// dual edge input cell, one per lane
// clk is assumed already phase shifted so the posedge sees the rise bit first
// capture flops carry no reset so outputs are junk until two edges have passed
`timescale 1ns/1ps
`default_nettype none

module ddr_in_cell
   import ddr_rx_pkg::*;
(
   input  logic     clk,
   input  logic     in,    // ddr data pin
   input  rx_mode_e mode,
   output logic     qrise,
   output logic     qfall
);

   logic rise_q;       // posedge capture
   logic fall_q;       // negedge capture
   logic rise_align_q; // rise capture delayed for pipe mode
   logic fall_align_q; // fall capture moved to posedge

   // ######################################
   // capture flops
   // ######################################
   always_ff @(posedge clk)
   begin
      rise_q <= in;
   end

   always_ff @(negedge clk)
   begin
      fall_q <= in;
   end

   // second stage on posedge
   always_ff @(posedge clk)
   begin
      rise_align_q <= rise_q;
      fall_align_q <= fall_q; // half cycle path from negedge flop
   end

   // ######################################
   // output select
   // ######################################
   always_comb
   begin
      case (mode)
         RX_SAMPLE:
         begin
            qrise = rise_q;
            qfall = fall_q;       // changes on negedge
         end
         RX_ALIGN:
         begin
            qrise = rise_q;
            qfall = fall_align_q;
         end
         RX_PIPE:
         begin
            qrise = rise_align_q; // bit k
            qfall = fall_align_q; // bit k + 1/2
         end
         default:
         begin
            qrise = in;           // bypass passes the pin straight through
            qfall = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/wb_pkg.sv
// wishbone classic bus types for the register port
// single 32-bit data path, byte address, no byte selects
`default_nettype none

package wb_pkg;

`include "ddr_rx_defines.svh"

   localparam int WB_AW = 4;  // byte address bits
   localparam int WB_DW = 32; // data bits

   // master to slave
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [WB_AW-1:0] adr; // byte address
      logic [WB_DW-1:0] dat; // write data
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat; // read data, valid with ack
   } wb_rsp_t;

   // register word indexes, taken from the byte offsets
   typedef enum logic [1:0] {
      REG_CTRL   = 2'(`DDR_REG_CTRL >> 2),
      REG_STATUS = 2'(`DDR_REG_STATUS >> 2),
      REG_DATA   = 2'(`DDR_REG_DATA >> 2),
      REG_SAMPLE = 2'(`DDR_REG_SAMPLE >> 2)
   } reg_addr_e;

endpackage

`default_nettype wire

// File: verilog/ddr_rx_pkg.sv
// receive path types, shared by the cells, gearbox and register block
// pair layout is fall bits on top, rise bits below
`default_nettype none

package ddr_rx_pkg;

`include "ddr_rx_defines.svh"

   // input cell operating modes, encodings fixed by the cell
   typedef enum logic [1:0] {
      RX_BYPASS = 2'd0, // live input, no capture
      RX_SAMPLE = 2'd1, // raw posedge / negedge captures
      RX_ALIGN  = 2'd2, // fall capture moved onto posedge
      RX_PIPE   = 2'd3  // rise and fall of one period together
   } rx_mode_e;

   // one clock period worth of lane data
   typedef struct packed {
      logic [`DDR_LANES-1:0] fall; // negedge bits
      logic [`DDR_LANES-1:0] rise; // posedge bits
   } rx_pair_t;

endpackage

`default_nettype wire

// File: verilog/ddr_rx_defines.svh
// shared sizes and register map for the ddr receiver
// DDR_WORD_W must stay equal to 2 * DDR_LANES * DDR_BEATS
// DDR_FIFO_DEPTH must be a power of two
`ifndef DDR_RX_DEFINES_SVH
`define DDR_RX_DEFINES_SVH

// receive path sizing
`define DDR_LANES       4                 // ddr input bits
`define DDR_BEATS       4                 // clock periods per word
`define DDR_WORD_W      32                // packed word width
`define DDR_FIFO_DEPTH  8                 // words, power of two
`define DDR_LEVEL_W     ($clog2(`DDR_FIFO_DEPTH) + 1)

// register byte offsets
`define DDR_REG_CTRL    4'h0
`define DDR_REG_STATUS  4'h4
`define DDR_REG_DATA    4'h8
`define DDR_REG_SAMPLE  4'hc

`endif
